/* source/rv_fetch_consts.svh */
`ifndef RV_FETCH_CONSTS_SVH
`define RV_FETCH_CONSTS_SVH

// byte address width of the instruction space
`define RV_FETCH_ADDR_BITS 16

// log2 of queue words
`define RV_FETCH_DEPTH_BITS 2

`define RV_FETCH_BOOT_PC 16'h0000

// register word offsets
`define RV_FETCH_REG_CTRL 2'd0
`define RV_FETCH_REG_TARGET 2'd1
`define RV_FETCH_REG_STATUS 2'd2

`endif

/* source/rv_fetch_pkg.sv */
`include "rv_fetch_consts.svh"

package rv_fetch_pkg;

    // byte address without bit 0
    typedef logic [`RV_FETCH_ADDR_BITS-1:1] half_pc_t;

    // byte address without bits 1..0
    typedef logic [`RV_FETCH_ADDR_BITS-1:2] word_addr_t;

    typedef logic [31:0] inst_word_t;

    typedef logic [31:0] reg_data_t;

    typedef enum logic [1:0]
    {
        bus_idle,
        bus_read,
        bus_drop   // waiting out an ack after a redirect
    } bus_state_t;

endpackage

/* source/rv_fetch_ctrl_regs.sv */
`include "rv_fetch_consts.svh"

module rv_fetch_ctrl_regs
    import rv_fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_cfg_cyc,
    input  logic       i_cfg_stb,
    input  logic       i_cfg_we,
    input  logic [1:0] i_cfg_adr,
    input  reg_data_t  i_cfg_dat,
    input  half_pc_t   i_fetch_pc,
    output reg_data_t  o_cfg_dat,
    output logic       o_cfg_ack,
    output logic       o_enable,
    output logic       o_redirect,
    output half_pc_t   o_target
);

    localparam logic [`RV_FETCH_ADDR_BITS-1:0] boot_byte = `RV_FETCH_BOOT_PC;
    localparam int pad_bits = 32 - `RV_FETCH_ADDR_BITS;

    logic access;

    // no new access while the previous one is being acked
    assign access = i_cfg_cyc && i_cfg_stb && !o_cfg_ack;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_cfg_ack  <= 1'b0;
            o_redirect <= 1'b0;
            o_enable   <= 1'b0;
            o_target   <= boot_byte[`RV_FETCH_ADDR_BITS-1:1];
        end
        else
        begin
            o_cfg_ack  <= access;
            o_redirect <= access && i_cfg_we && (i_cfg_adr == `RV_FETCH_REG_TARGET);
            if (access && i_cfg_we)
            begin
                case (i_cfg_adr)
                    `RV_FETCH_REG_CTRL:   o_enable <= i_cfg_dat[0];
                    `RV_FETCH_REG_TARGET: o_target <= i_cfg_dat[`RV_FETCH_ADDR_BITS-1:1];
                    default: ;   // status is read-only
                endcase
            end
        end
    end

    // read data, presented with ack
    always_ff @(posedge i_clk)
    begin
        if (access)
        begin
            case (i_cfg_adr)
                `RV_FETCH_REG_CTRL:   o_cfg_dat <= {31'b0, o_enable};
                `RV_FETCH_REG_TARGET: o_cfg_dat <= {{pad_bits{1'b0}}, o_target, 1'b0};
                `RV_FETCH_REG_STATUS: o_cfg_dat <= {{pad_bits{1'b0}}, i_fetch_pc, 1'b0};
                default:              o_cfg_dat <= '0;
            endcase
        end
    end

endmodule

/* source/rv_fetch_bus_master.sv */
`include "rv_fetch_consts.svh"

module rv_fetch_bus_master
    import rv_fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_enable,
    input  logic       i_redirect,
    input  half_pc_t   i_target,
    input  logic       i_not_full,
    input  inst_word_t i_imem_dat,
    input  logic       i_imem_ack,
    output logic       o_imem_cyc,
    output logic       o_imem_stb,
    output word_addr_t o_imem_adr,
    output logic       o_push,
    output inst_word_t o_push_data
);

    localparam logic [`RV_FETCH_ADDR_BITS-1:0] boot_byte = `RV_FETCH_BOOT_PC;

    bus_state_t state;
    word_addr_t fetch_addr;   // next word to request
    word_addr_t target_word;
    logic       start;

    assign target_word = i_target[`RV_FETCH_ADDR_BITS-1:2];
    assign start       = (state == bus_idle) && !i_redirect && i_enable && i_not_full;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state      <= bus_idle;
            fetch_addr <= boot_byte[`RV_FETCH_ADDR_BITS-1:2];
        end
        else
        begin
            case (state)
                bus_idle:
                begin
                    if (i_redirect)
                        fetch_addr <= target_word;
                    else if (start)
                        state <= bus_read;
                end
                bus_read:
                begin
                    if (i_redirect)
                    begin
                        fetch_addr <= target_word;
                        state      <= i_imem_ack ? bus_idle : bus_drop;
                    end
                    else if (i_imem_ack)
                    begin
                        fetch_addr <= fetch_addr + word_addr_t'(1);
                        state      <= bus_idle;
                    end
                end
                bus_drop:
                begin
                    if (i_redirect)
                        fetch_addr <= target_word;
                    if (i_imem_ack)
                        state <= bus_idle;   // stale word thrown away
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // address held steady for the whole cycle, even across a redirect
    always_ff @(posedge i_clk)
    begin
        if (start)
            o_imem_adr <= fetch_addr;
    end

    assign o_imem_cyc  = (state != bus_idle);
    assign o_imem_stb  = (state != bus_idle);
    assign o_push      = (state == bus_read) && i_imem_ack && !i_redirect;
    assign o_push_data = i_imem_dat;

endmodule

/* source/rv_fetch_buf.sv */
`include "rv_fetch_consts.svh"

module rv_fetch_buf
    import rv_fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_flush,
    input  half_pc_t   i_flush_pc,
    input  logic       i_push,
    input  inst_word_t i_push_data,
    input  logic       i_inst_stall,
    output logic       o_not_full,
    output logic       o_inst_valid,
    output inst_word_t o_inst_data,
    output half_pc_t   o_inst_pc,
    output half_pc_t   o_fetch_pc
);

    localparam int q_size = 2 ** `RV_FETCH_DEPTH_BITS;
    localparam logic [`RV_FETCH_ADDR_BITS-1:0] boot_byte = `RV_FETCH_BOOT_PC;
    localparam logic [q_size:0] fill_empty = 1;

    inst_word_t        data [q_size];
    logic [q_size:0]   fill_oh;    // one-hot word count, bit 0 means empty
    half_pc_t          pc;
    half_pc_t          pc_step;
    logic [15:0]       latch_hi;   // upper half of the last popped word
    logic              hi_valid;
    logic              head_valid;
    logic              use_latch;
    logic [15:0]       data_lo;
    logic [15:0]       data_hi;
    logic              is_comp;
    logic              inst_valid;
    logic              preload;
    logic              consume;
    logic              pop;

    assign head_valid = !fill_oh[0];
    assign use_latch  = pc[1] && hi_valid;

    always_comb
    begin
        if (use_latch)
            data_lo = latch_hi;
        else if (pc[1])
            data_lo = data[0][31:16];
        else
            data_lo = data[0][15:0];
    end

    assign is_comp = (data_lo[1:0] != 2'b11);

    // upper half forced to zero for compressed so it holds under a stall
    assign data_hi = is_comp ? 16'h0000 : (pc[1] ? data[0][15:0] : data[0][31:16]);

    assign inst_valid = use_latch ? (is_comp || head_valid)
                                  : (head_valid && (is_comp || !pc[1]));

    // 32-bit instruction starting in the upper half, move that half to the latch first
    assign preload = pc[1] && !hi_valid && head_valid && !is_comp;
    assign consume = inst_valid && !i_inst_stall;
    assign pop     = preload || (consume && (pc[1] ? !(hi_valid && is_comp) : !is_comp));
    assign pc_step = is_comp ? half_pc_t'(1) : half_pc_t'(2);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            fill_oh  <= fill_empty;
            hi_valid <= 1'b0;
            pc       <= boot_byte[`RV_FETCH_ADDR_BITS-1:1];
        end
        else if (i_flush)
        begin
            fill_oh  <= fill_empty;
            hi_valid <= 1'b0;
            pc       <= i_flush_pc;
        end
        else
        begin
            if (i_push && !pop)
                fill_oh <= fill_oh << 1;
            else if (pop && !i_push)
                fill_oh <= fill_oh >> 1;

            if (preload)
                hi_valid <= 1'b1;
            else if (consume && use_latch && is_comp)
                hi_valid <= 1'b0;   // latched half used up

            if (consume)
                pc <= pc + pc_step;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (pop)
            latch_hi <= data[0][31:16];
    end

    for (genvar i = 0; i < q_size; i++)
    begin : g_slot
        inst_word_t upper;

        if (i == q_size - 1)
        begin : g_last
            assign upper = data[i];
        end
        else
        begin : g_mid
            assign upper = data[i + 1];
        end

        always_ff @(posedge i_clk)
        begin
            if (pop)
            begin
                if (i_push && fill_oh[i + 1])
                    data[i] <= i_push_data;   // shift in behind the pop
                else
                    data[i] <= upper;
            end
            else if (i_push && fill_oh[i])
            begin
                data[i] <= i_push_data;
            end
        end
    end

    assign o_not_full   = !fill_oh[q_size];
    assign o_inst_valid = inst_valid;
    assign o_inst_data  = {data_hi, data_lo};
    assign o_inst_pc    = pc;
    assign o_fetch_pc   = pc;

endmodule

/* source/rv_fetch_top.sv */
module rv_fetch_top
    import rv_fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_cfg_cyc,
    input  logic       i_cfg_stb,
    input  logic       i_cfg_we,
    input  logic [1:0] i_cfg_adr,
    input  reg_data_t  i_cfg_dat,
    output reg_data_t  o_cfg_dat,
    output logic       o_cfg_ack,
    output logic       o_imem_cyc,
    output logic       o_imem_stb,
    output word_addr_t o_imem_adr,
    input  inst_word_t i_imem_dat,
    input  logic       i_imem_ack,
    output logic       o_inst_valid,
    output inst_word_t o_inst_data,
    output half_pc_t   o_inst_pc,
    input  logic       i_inst_stall
);

    logic       enable;
    logic       redirect;
    half_pc_t   target;
    half_pc_t   fetch_pc;
    logic       not_full;
    logic       push;
    inst_word_t push_data;

    rv_fetch_ctrl_regs u_regs
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_cfg_cyc  (i_cfg_cyc),
        .i_cfg_stb  (i_cfg_stb),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_adr  (i_cfg_adr),
        .i_cfg_dat  (i_cfg_dat),
        .i_fetch_pc (fetch_pc),
        .o_cfg_dat  (o_cfg_dat),
        .o_cfg_ack  (o_cfg_ack),
        .o_enable   (enable),
        .o_redirect (redirect),
        .o_target   (target)
    );

    rv_fetch_bus_master u_master
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_enable    (enable),
        .i_redirect  (redirect),
        .i_target    (target),
        .i_not_full  (not_full),
        .i_imem_dat  (i_imem_dat),
        .i_imem_ack  (i_imem_ack),
        .o_imem_cyc  (o_imem_cyc),
        .o_imem_stb  (o_imem_stb),
        .o_imem_adr  (o_imem_adr),
        .o_push      (push),
        .o_push_data (push_data)
    );

    // redirect doubles as queue flush
    rv_fetch_buf u_buf
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (redirect),
        .i_flush_pc   (target),
        .i_push       (push),
        .i_push_data  (push_data),
        .i_inst_stall (i_inst_stall),
        .o_not_full   (not_full),
        .o_inst_valid (o_inst_valid),
        .o_inst_data  (o_inst_data),
        .o_inst_pc    (o_inst_pc),
        .o_fetch_pc   (fetch_pc)
    );

endmodule

/* testbench/tb_rv_fetch_mem.sv */
`include "rv_fetch_consts.svh"

module tb_rv_fetch_mem
    import rv_fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_cyc,
    input  logic       i_stb,
    input  word_addr_t i_adr,
    input  logic [1:0] i_waits,
    output inst_word_t o_dat,
    output logic       o_ack
);

    // 2 KB, upper address bits alias
    inst_word_t mem [512];
    logic [1:0] count;    // wait states still to go
    logic       busy;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_ack <= 1'b0;
            busy  <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            o_ack <= 1'b0;
            if (i_cyc && i_stb && !o_ack)
            begin
                if (!busy && i_waits != 2'd0)
                begin
                    busy  <= 1'b1;
                    count <= i_waits - 2'd1;
                end
                else if (busy && count != 2'd0)
                    count <= count - 2'd1;
                else
                begin
                    busy  <= 1'b0;
                    o_ack <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_cyc && i_stb && !o_ack)
            o_dat <= mem[i_adr[10:2]];
    end

endmodule

/* testbench/tb_rv_fetch.sv */
`include "rv_fetch_consts.svh"

module tb_rv_fetch
    import rv_fetch_pkg::*;
();

    localparam int stream_len   = 40;
    localparam int num_tests    = 6;
    localparam int slack_cycles = 20;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       cfg_cyc;
    logic       cfg_stb;
    logic       cfg_we;
    logic [1:0] cfg_adr;
    reg_data_t  cfg_dat_w;
    reg_data_t  cfg_dat_r;
    logic       cfg_ack;
    logic       imem_cyc;
    logic       imem_stb;
    logic       imem_ack;
    word_addr_t imem_adr;
    inst_word_t imem_dat;
    logic [1:0] mem_waits;
    logic       inst_valid;
    logic       inst_stall;
    inst_word_t inst_data;
    half_pc_t   inst_pc;
    logic       consume;
    logic       target_ack;

    logic [15:0] lfsr = 16'd48329;
    bit          stall_mode = 1'b0;
    bit          no_fetch = 1'b0;    // set once a disable has settled
    string       test_name = "startup";
    int          errors = 0;
    int          test_errors_at = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          consumed = 0;
    int          exp_idx = 0;
    bit          exp_avail = 1'b0;
    half_pc_t    cur_pc;
    inst_word_t  cur_data;
    half_pc_t    exp_pc_q[$];
    inst_word_t  exp_data_q[$];
    half_pc_t    pend_pc_q[$];    // stream that starts at the next TARGET write
    inst_word_t  pend_data_q[$];

    rv_fetch_top dut
    (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_cfg_cyc    (cfg_cyc),
        .i_cfg_stb    (cfg_stb),
        .i_cfg_we     (cfg_we),
        .i_cfg_adr    (cfg_adr),
        .i_cfg_dat    (cfg_dat_w),
        .o_cfg_dat    (cfg_dat_r),
        .o_cfg_ack    (cfg_ack),
        .o_imem_cyc   (imem_cyc),
        .o_imem_stb   (imem_stb),
        .o_imem_adr   (imem_adr),
        .i_imem_dat   (imem_dat),
        .i_imem_ack   (imem_ack),
        .o_inst_valid (inst_valid),
        .o_inst_data  (inst_data),
        .o_inst_pc    (inst_pc),
        .i_inst_stall (inst_stall)
    );

    tb_rv_fetch_mem u_mem
    (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_cyc    (imem_cyc),
        .i_stb    (imem_stb),
        .i_adr    (imem_adr),
        .i_waits  (mem_waits),
        .o_dat    (imem_dat),
        .o_ack    (imem_ack)
    );

    always #5 clk = ~clk;

    assign consume    = inst_valid && !inst_stall;
    assign target_ack = cfg_ack && cfg_we && (cfg_adr == `RV_FETCH_REG_TARGET);

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr[0];
        lfsr = lfsr >> 1;
        if (out_bit)
            lfsr = lfsr ^ 16'hB400;
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [15:0] mem_half(input logic [15:0] addr);
        inst_word_t word;
        word = u_mem.mem[addr[10:2]];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    // parse the image by the compressed rule
    task automatic load_next(input logic [15:0] start);
        logic [15:0] addr;
        logic [15:0] lo;
        pend_pc_q.delete();
        pend_data_q.delete();
        addr = start;
        repeat (stream_len + 16)
        begin
            lo = mem_half(addr);
            pend_pc_q.push_back(addr[15:1]);
            if (lo[1:0] != 2'b11)
            begin
                pend_data_q.push_back({16'h0000, lo});
                addr = addr + 16'd2;
            end
            else
            begin
                pend_data_q.push_back({mem_half(addr + 16'd2), lo});
                addr = addr + 16'd4;
            end
        end
    endtask

    // stimulus, LFSR stepped every cycle so the sequence does not hinge on stall_mode
    always @(negedge clk)
    begin
        mem_waits  = rand_bits(2);
        inst_stall = (rand_bits(1) != 0) && stall_mode;
    end

    // expected stream tracking
    always @(posedge clk)
    begin
        if (consume)
        begin
            exp_idx++;
            consumed++;
        end
        if (target_ack)
        begin
            exp_pc_q   = pend_pc_q;
            exp_data_q = pend_data_q;
            exp_idx    = 0;
            consumed   = 0;
        end
        exp_avail = (exp_idx < exp_pc_q.size());
        if (exp_avail)
        begin
            cur_pc   = exp_pc_q[exp_idx];
            cur_data = exp_data_q[exp_idx];
        end
    end

    a_stream_left: assert property (@(posedge clk) disable iff (!arst_n) consume |-> exp_avail)
        else
        begin
            $display("%s: instruction delivered with no expected entry left", test_name);
            errors++;
        end

    a_inst_pc: assert property (@(posedge clk) disable iff (!arst_n)
        (consume && exp_avail) |-> inst_pc == cur_pc)
        else
        begin
            $display("FAIL %s: pc expected %h actual %h", test_name,
                     $sampled(cur_pc), $sampled(inst_pc));
            errors++;
        end

    a_inst_data: assert property (@(posedge clk) disable iff (!arst_n)
        (consume && exp_avail) |-> inst_data == cur_data)
        else
        begin
            $display("FAIL %s: instruction expected %h actual %h", test_name,
                     $sampled(cur_data), $sampled(inst_data));
            errors++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_valid && inst_stall && !target_ack)
        |=> (inst_valid && $stable(inst_data) && $stable(inst_pc)))
        else
        begin
            $display("%s: head instruction changed while decode was stalled", test_name);
            errors++;
        end

    a_cfg_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (cfg_cyc && cfg_stb && !cfg_ack) |=> cfg_ack)
        else
        begin
            $display("%s: register ack did not follow stb by one cycle", test_name);
            errors++;
        end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n) target_ack |=> !inst_valid)
        else
        begin
            $display("%s: instruction valid in the cycle after a redirect", test_name);
            errors++;
        end

    a_no_fetch: assert property (@(posedge clk) disable iff (!arst_n) no_fetch |-> !$rose(imem_stb))
        else
        begin
            $display("%s: bus read started while fetch was disabled", test_name);
            errors++;
        end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // called and returns just after a falling edge
    task automatic reg_access(input logic we, input logic [1:0] adr, input reg_data_t wdata,
                              output reg_data_t rdata);
        int waited;
        cfg_cyc   = 1'b1;
        cfg_stb   = 1'b1;
        cfg_we    = we;
        cfg_adr   = adr;
        cfg_dat_w = wdata;
        waited    = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!cfg_ack && waited < 4);
        if (!cfg_ack)
        begin
            $display("%s: register port gave no ack", test_name);
            errors++;
        end
        rdata   = cfg_dat_r;
        cfg_cyc = 1'b0;
        cfg_stb = 1'b0;
        @(negedge clk);    // we and adr held through the ack cycle
    endtask

    task automatic reg_write(input logic [1:0] adr, input reg_data_t wdata);
        reg_data_t unused;
        reg_access(1'b1, adr, wdata, unused);
    endtask

    task automatic reg_read(input logic [1:0] adr, output reg_data_t rdata);
        reg_access(1'b0, adr, 32'h0, rdata);
    endtask

    task automatic wait_consumed(input int n);
        while (consumed < n)
            @(negedge clk);
    endtask

    task automatic stop_fetch();
        reg_write(`RV_FETCH_REG_CTRL, 32'h0);
        while (imem_cyc)
            @(negedge clk);
        repeat (16) @(negedge clk);    // let the queue drain
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_errors_at = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors_at)
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_errors_at);
        end
        else
            $display("test %s: passed", test_name);
    endtask

    task automatic test_reset_regs();
        reg_data_t rd;
        begin_test("reset_regs");
        repeat (8)
        begin
            check_value("inst_valid", 32'h0, inst_valid);
            check_value("imem_cyc", 32'h0, imem_cyc);
            @(negedge clk);
        end
        reg_read(`RV_FETCH_REG_CTRL, rd);
        check_value("ctrl", 32'h0, rd);
        reg_read(`RV_FETCH_REG_TARGET, rd);
        check_value("target", 32'h0, rd);
        reg_read(`RV_FETCH_REG_STATUS, rd);
        check_value("status", {16'h0, `RV_FETCH_BOOT_PC}, rd);
        reg_write(`RV_FETCH_REG_TARGET, 32'h0000_0124);
        reg_read(`RV_FETCH_REG_TARGET, rd);
        check_value("target readback", 32'h0000_0124, rd);
        end_test();
    endtask

    task automatic stream_test(input string name, input logic [15:0] start, input bit stalls);
        begin_test(name);
        load_next(start);
        reg_write(`RV_FETCH_REG_TARGET, {16'h0, start});
        stall_mode = stalls;
        reg_write(`RV_FETCH_REG_CTRL, 32'h1);
        wait_consumed(stream_len);
        stall_mode = 1'b0;
        stop_fetch();
        end_test();
    endtask

    task automatic test_redirect_mid();
        begin_test("redirect_mid");
        load_next(16'h0200);
        reg_write(`RV_FETCH_REG_TARGET, 32'h0000_0200);
        reg_write(`RV_FETCH_REG_CTRL, 32'h1);
        wait_consumed(10);
        load_next(16'h031A);
        while (imem_cyc)
            @(negedge clk);
        while (!imem_cyc)
            @(negedge clk);    // a read has just started
        reg_write(`RV_FETCH_REG_TARGET, 32'h0000_031A);    // lands on a read in flight
        wait_consumed(stream_len / 2);
        stop_fetch();
        end_test();
    endtask

    task automatic test_disable();
        reg_data_t first;
        reg_data_t second;
        begin_test("disable");
        load_next(16'h00E0);
        reg_write(`RV_FETCH_REG_TARGET, 32'h0000_00E0);
        reg_write(`RV_FETCH_REG_CTRL, 32'h1);
        wait_consumed(8);
        stop_fetch();
        no_fetch = 1'b1;
        repeat (8) @(negedge clk);
        reg_read(`RV_FETCH_REG_STATUS, first);
        repeat (10) @(negedge clk);
        reg_read(`RV_FETCH_REG_STATUS, second);
        check_value("status stable", first, second);
        check_value("status pc", {16'h0, cur_pc, 1'b0}, second);
        no_fetch = 1'b0;
        end_test();
    endtask

    initial
    begin
        #(num_tests * stream_len * slack_cycles * 10);
        $display("watchdog expired while test %s was running", test_name);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        arst_n     = 1'b0;
        cfg_cyc    = 1'b0;
        cfg_stb    = 1'b0;
        cfg_we     = 1'b0;
        cfg_adr    = 2'd0;
        cfg_dat_w  = '0;
        inst_stall = 1'b0;
        mem_waits  = 2'd0;
        for (int i = 0; i < 512; i++)
            u_mem.mem[i] = rand_bits(32);    // about one halfword in four starts a 32-bit op
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_regs();
        stream_test("word_aligned", 16'h0040, 1'b0);
        stream_test("half_aligned", 16'h00A2, 1'b0);
        stream_test("decode_stalls", 16'h0106, 1'b1);
        test_redirect_mid();
        test_disable();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/rv_fetch_pkg.sv
source/rv_fetch_ctrl_regs.sv
source/rv_fetch_bus_master.sv
source/rv_fetch_buf.sv
source/rv_fetch_top.sv
testbench/tb_rv_fetch_mem.sv
testbench/tb_rv_fetch.sv

/* Bender.yml */
package:
  name: rv_fetch

sources:
  - include_dirs:
      - source
    files:
      - source/rv_fetch_pkg.sv
      - source/rv_fetch_ctrl_regs.sv
      - source/rv_fetch_bus_master.sv
      - source/rv_fetch_buf.sv
      - source/rv_fetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_rv_fetch_mem.sv
      - testbench/tb_rv_fetch.sv
